// ==== iq_pkg.sv ====
package iq_pkg;

    // queue geometry
    localparam int IQ_SIZE = 16;
    localparam int IQ_PTR_W = $clog2(IQ_SIZE);

    // core-wide sizes seen by the queue
    localparam int AL_SIZE = 64;
    localparam int AL_TAG_W = $clog2(AL_SIZE);
    localparam int NUM_PR = 64;
    localparam int PR_W = $clog2(NUM_PR);
    localparam int ADDR_W = 32;
    localparam int NUM_LANES = 2;
    localparam int NUM_WB = 4;

    typedef logic [AL_TAG_W-1:0] al_tag_t;
    typedef logic [PR_W-1:0] pr_tag_t;
    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;
    // one extra bit so a full queue can be counted
    typedef logic [IQ_PTR_W:0] iq_count_t;

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_e;

    // follows the riscv load/store funct3 encoding
    typedef enum logic [2:0] {
        W_BYTE  = 3'b000,
        W_HALF  = 3'b001,
        W_WORD  = 3'b010,
        W_UBYTE = 3'b100,
        W_UHALF = 3'b101
    } mem_width_e;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        pr_tag_t rs1;
        pr_tag_t rs2;
        pr_tag_t rd;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        logic uses_imm;
        logic [31:0] imm;
        logic is_mem_access;
        logic accesses_csr;
        mem_op_e mem_op;
        mem_width_e width;
        al_tag_t al_addr;
    } iq_entry_t;

endpackage

// ==== iq_alloc_if.sv ====
`timescale 1ns/1ps

// per write port: enable, target slot, payload and incoming source-ready bits
interface iq_alloc_if;

    logic alloc_we [iq_pkg::NUM_LANES];
    iq_pkg::iq_ptr_t alloc_slot [iq_pkg::NUM_LANES];
    iq_pkg::iq_entry_t alloc_entry [iq_pkg::NUM_LANES];
    // bit 0 is rs1_ready, bit 1 is rs2_ready
    logic [1:0] alloc_src_ready [iq_pkg::NUM_LANES];

    modport alloc (
        output alloc_we,
        output alloc_slot,
        output alloc_entry,
        output alloc_src_ready
    );

    modport store (
        input alloc_we,
        input alloc_slot,
        input alloc_entry,
        input alloc_src_ready
    );

endinterface

// ==== iq_alloc.sv ====
`timescale 1ns/1ps

module iq_alloc (
    input  logic clk,
    input  logic reset,
    input  logic i_ren_valid [iq_pkg::NUM_LANES],
    input  iq_pkg::iq_entry_t i_ren_entry [iq_pkg::NUM_LANES],
    input  logic [1:0] i_ren_src_ready [iq_pkg::NUM_LANES],
    input  logic i_recall,
    input  logic [iq_pkg::IQ_SIZE-1:0] i_valid,
    input  iq_pkg::iq_ptr_t i_new_front,
    output logic o_stall,
    iq_alloc_if.alloc o_alloc
);

    iq_pkg::iq_ptr_t front_ptr;
    iq_pkg::iq_ptr_t front_nxt;
    iq_pkg::iq_count_t occupancy;
    iq_pkg::iq_count_t num_in;
    logic in_order [iq_pkg::NUM_LANES];
    logic accept;

    // only memory and csr ops go through this queue
    always_comb begin
        for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
            in_order[l] = i_ren_valid[l] &&
                          (i_ren_entry[l].is_mem_access || i_ren_entry[l].accesses_csr);
        end
    end

    always_comb begin
        occupancy = '0;
        for (int i = 0; i < iq_pkg::IQ_SIZE; i++) begin
            occupancy = occupancy + iq_pkg::iq_count_t'(i_valid[i]);
        end
    end

    assign num_in = iq_pkg::iq_count_t'(in_order[0]) + iq_pkg::iq_count_t'(in_order[1]);

    // conservative, stalls even if the issue this cycle would free room
    assign o_stall = (occupancy + num_in) >= iq_pkg::iq_count_t'(iq_pkg::IQ_SIZE);
    assign accept = !o_stall && !i_recall;

    assign front_nxt = front_ptr + 1'b1;

    // lane 0 always lands at front, lane 1 packs behind it when both count
    always_comb begin
        for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
            o_alloc.alloc_we[l] = in_order[l] && accept;
            o_alloc.alloc_entry[l] = i_ren_entry[l];
            o_alloc.alloc_src_ready[l] = i_ren_src_ready[l];
        end
        o_alloc.alloc_slot[0] = front_ptr;
        o_alloc.alloc_slot[1] = in_order[0] ? front_nxt : front_ptr;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            front_ptr <= '0;
        end else if (i_recall) begin
            // rewound slot from the flush logic
            front_ptr <= i_new_front;
        end else if (accept) begin
            front_ptr <= front_ptr + iq_pkg::iq_ptr_t'(num_in);
        end
    end

endmodule

// ==== iq_flush.sv ====
`timescale 1ns/1ps

module iq_flush (
    input  logic i_recall,
    input  iq_pkg::al_tag_t i_new_front,
    input  iq_pkg::al_tag_t i_old_front,
    input  logic [iq_pkg::IQ_SIZE-1:0] i_valid,
    input  iq_pkg::al_tag_t i_al_addr [iq_pkg::IQ_SIZE],
    input  iq_pkg::iq_ptr_t i_back_ptr,
    output logic [iq_pkg::IQ_SIZE-1:0] o_flush_mask,
    output iq_pkg::iq_ptr_t o_new_front
);

    logic wrap;
    logic [iq_pkg::IQ_SIZE-1:0] in_range;

    // flushed range is [new_front, old_front) on the circular active list
    assign wrap = i_new_front > i_old_front;

    always_comb begin
        for (int i = 0; i < iq_pkg::IQ_SIZE; i++) begin
            if (wrap) begin
                in_range[i] = (i_al_addr[i] >= i_new_front) || (i_al_addr[i] < i_old_front);
            end else begin
                in_range[i] = (i_al_addr[i] >= i_new_front) && (i_al_addr[i] < i_old_front);
            end
            o_flush_mask[i] = i_recall && i_valid[i] && in_range[i];
        end
    end

    // valid entries sit contiguously from back, so back plus the live count
    // is the current front; any flushed slot nearer the back replaces it
    always_comb begin
        iq_pkg::iq_count_t live;
        iq_pkg::iq_ptr_t slot;
        live = '0;
        for (int i = 0; i < iq_pkg::IQ_SIZE; i++) begin
            live = live + iq_pkg::iq_count_t'(i_valid[i]);
        end
        o_new_front = i_back_ptr + iq_pkg::iq_ptr_t'(live);
        // walk from youngest offset down so the oldest flushed slot wins
        for (int i = iq_pkg::IQ_SIZE - 1; i >= 0; i--) begin
            slot = i_back_ptr + iq_pkg::iq_ptr_t'(i);
            if (o_flush_mask[slot]) begin
                o_new_front = slot;
            end
        end
    end

endmodule

// ==== iq_wakeup.sv ====
`timescale 1ns/1ps

module iq_wakeup (
    input  logic clk,
    input  logic reset,
    iq_alloc_if.store i_alloc,
    input  logic [iq_pkg::IQ_SIZE-1:0] i_valid,
    input  logic i_wb_valid [iq_pkg::NUM_WB],
    input  logic i_wb_uses_rd [iq_pkg::NUM_WB],
    input  iq_pkg::pr_tag_t i_wb_rd [iq_pkg::NUM_WB],
    output logic [iq_pkg::IQ_SIZE-1:0] o_entry_ready
);

    iq_pkg::pr_tag_t rs1_tag [iq_pkg::IQ_SIZE];
    iq_pkg::pr_tag_t rs2_tag [iq_pkg::IQ_SIZE];
    logic [iq_pkg::IQ_SIZE-1:0] rs1_rdy;
    logic [iq_pkg::IQ_SIZE-1:0] rs2_rdy;

    // true if any writeback port produces this tag in the current cycle
    function automatic logic wb_hit(input iq_pkg::pr_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < iq_pkg::NUM_WB; k++) begin
            hit |= i_wb_valid[k] && i_wb_uses_rd[k] && (i_wb_rd[k] == tag);
        end
        return hit;
    endfunction

    always_ff @(posedge clk) begin
        for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
            if (i_alloc.alloc_we[l]) begin
                rs1_tag[i_alloc.alloc_slot[l]] <= i_alloc.alloc_entry[l].rs1;
                rs2_tag[i_alloc.alloc_slot[l]] <= i_alloc.alloc_entry[l].rs2;
            end
        end
    end

    // an unused source is marked ready at allocation, so only used ones
    // ever wait on a writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            rs1_rdy <= '0;
            rs2_rdy <= '0;
        end else begin
            for (int j = 0; j < iq_pkg::IQ_SIZE; j++) begin
                if (i_valid[j] && wb_hit(rs1_tag[j])) begin
                    rs1_rdy[j] <= 1'b1;
                end
                if (i_valid[j] && wb_hit(rs2_tag[j])) begin
                    rs2_rdy[j] <= 1'b1;
                end
            end
            // same-cycle writeback catches a tag the busy table missed
            for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
                if (i_alloc.alloc_we[l]) begin
                    rs1_rdy[i_alloc.alloc_slot[l]] <= !i_alloc.alloc_entry[l].uses_rs1 ||
                        i_alloc.alloc_src_ready[l][0] || wb_hit(i_alloc.alloc_entry[l].rs1);
                    rs2_rdy[i_alloc.alloc_slot[l]] <= !i_alloc.alloc_entry[l].uses_rs2 ||
                        i_alloc.alloc_src_ready[l][1] || wb_hit(i_alloc.alloc_entry[l].rs2);
                end
            end
        end
    end

    assign o_entry_ready = rs1_rdy & rs2_rdy;

endmodule

// ==== iq_entries.sv ====
`timescale 1ns/1ps

module iq_entries (
    input  logic clk,
    input  logic reset,
    iq_alloc_if.store i_alloc,
    input  logic [iq_pkg::IQ_SIZE-1:0] i_entry_ready,
    input  logic i_recall,
    input  logic [iq_pkg::IQ_SIZE-1:0] i_flush_mask,
    output logic [iq_pkg::IQ_SIZE-1:0] o_valid,
    output iq_pkg::al_tag_t o_al_addr [iq_pkg::IQ_SIZE],
    output iq_pkg::iq_ptr_t o_back_ptr,
    output logic o_iss_valid [iq_pkg::NUM_LANES],
    output iq_pkg::iq_entry_t o_iss_entry [iq_pkg::NUM_LANES]
);

    iq_pkg::iq_entry_t entries [iq_pkg::IQ_SIZE];
    logic [iq_pkg::IQ_SIZE-1:0] valid;
    iq_pkg::iq_ptr_t back_ptr;
    iq_pkg::iq_ptr_t back_nxt;
    logic can_iss [iq_pkg::NUM_LANES];

    assign back_nxt = back_ptr + 1'b1;

    // strictly in order, lane 1 only goes behind lane 0
    assign can_iss[0] = valid[back_ptr] && i_entry_ready[back_ptr] && !i_flush_mask[back_ptr];
    assign can_iss[1] = can_iss[0] && valid[back_nxt] && i_entry_ready[back_nxt] &&
                        !i_flush_mask[back_nxt];

    // payload storage and the issue registers
    always_ff @(posedge clk) begin
        for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
            if (i_alloc.alloc_we[l]) begin
                entries[i_alloc.alloc_slot[l]] <= i_alloc.alloc_entry[l];
            end
        end
        if (can_iss[0]) begin
            o_iss_entry[0] <= entries[back_ptr];
        end
        if (can_iss[1]) begin
            o_iss_entry[1] <= entries[back_nxt];
        end
    end

    // later assignments win, so issue clears override the flush copy
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            back_ptr <= '0;
            for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
                o_iss_valid[l] <= 1'b0;
            end
        end else begin
            if (i_recall) begin
                valid <= valid & ~i_flush_mask;
            end
            for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
                if (i_alloc.alloc_we[l]) begin
                    valid[i_alloc.alloc_slot[l]] <= 1'b1;
                end
                o_iss_valid[l] <= can_iss[l];
            end
            if (can_iss[1]) begin
                valid[back_ptr] <= 1'b0;
                valid[back_nxt] <= 1'b0;
                back_ptr <= back_ptr + 2'd2;
            end else if (can_iss[0]) begin
                valid[back_ptr] <= 1'b0;
                back_ptr <= back_nxt;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < iq_pkg::IQ_SIZE; i++) begin
            o_al_addr[i] = entries[i].al_addr;
        end
    end

    assign o_valid = valid;
    assign o_back_ptr = back_ptr;

endmodule

// ==== mem_issue_queue.sv ====
`timescale 1ns/1ps

module mem_issue_queue (
    input  logic clk,
    input  logic reset,
    // rename
    input  logic i_ren_valid [iq_pkg::NUM_LANES],
    input  iq_pkg::iq_entry_t i_ren_entry [iq_pkg::NUM_LANES],
    input  logic [1:0] i_ren_src_ready [iq_pkg::NUM_LANES],
    // writeback snoop
    input  logic i_wb_valid [iq_pkg::NUM_WB],
    input  logic i_wb_uses_rd [iq_pkg::NUM_WB],
    input  iq_pkg::pr_tag_t i_wb_rd [iq_pkg::NUM_WB],
    // recall from the active list
    input  logic i_recall,
    input  iq_pkg::al_tag_t i_new_front,
    input  iq_pkg::al_tag_t i_old_front,
    output logic o_stall,
    // issue to the memory / csr pipe
    output logic o_iss_valid [iq_pkg::NUM_LANES],
    output iq_pkg::iq_entry_t o_iss_entry [iq_pkg::NUM_LANES]
);

    logic [iq_pkg::IQ_SIZE-1:0] valid;
    iq_pkg::al_tag_t al_addr [iq_pkg::IQ_SIZE];
    iq_pkg::iq_ptr_t back_ptr;
    logic [iq_pkg::IQ_SIZE-1:0] flush_mask;
    iq_pkg::iq_ptr_t new_front;
    logic [iq_pkg::IQ_SIZE-1:0] entry_ready;

    iq_alloc_if alloc_bus ();

    iq_alloc u_alloc (
        .clk             (clk),
        .reset           (reset),
        .i_ren_valid     (i_ren_valid),
        .i_ren_entry     (i_ren_entry),
        .i_ren_src_ready (i_ren_src_ready),
        .i_recall        (i_recall),
        .i_valid         (valid),
        .i_new_front     (new_front),
        .o_stall         (o_stall),
        .o_alloc         (alloc_bus.alloc)
    );

    iq_flush u_flush (
        .i_recall     (i_recall),
        .i_new_front  (i_new_front),
        .i_old_front  (i_old_front),
        .i_valid      (valid),
        .i_al_addr    (al_addr),
        .i_back_ptr   (back_ptr),
        .o_flush_mask (flush_mask),
        .o_new_front  (new_front)
    );

    iq_wakeup u_wakeup (
        .clk           (clk),
        .reset         (reset),
        .i_alloc       (alloc_bus.store),
        .i_valid       (valid),
        .i_wb_valid    (i_wb_valid),
        .i_wb_uses_rd  (i_wb_uses_rd),
        .i_wb_rd       (i_wb_rd),
        .o_entry_ready (entry_ready)
    );

    iq_entries u_entries (
        .clk           (clk),
        .reset         (reset),
        .i_alloc       (alloc_bus.store),
        .i_entry_ready (entry_ready),
        .i_recall      (i_recall),
        .i_flush_mask  (flush_mask),
        .o_valid       (valid),
        .o_al_addr     (al_addr),
        .o_back_ptr    (back_ptr),
        .o_iss_valid   (o_iss_valid),
        .o_iss_entry   (o_iss_entry)
    );

endmodule

// ==== tb_mem_issue_queue.sv ====
`timescale 1ns/1ps

module tb_mem_issue_queue;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_LIMIT = 30;
    localparam int NUM_TESTS = 6;
    // longest test drives about twenty cycles before it drains
    localparam int TEST_CYCLES = 20 + DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 50;

    logic clk;
    logic reset;
    logic ren_valid [iq_pkg::NUM_LANES];
    iq_pkg::iq_entry_t ren_entry [iq_pkg::NUM_LANES];
    logic [1:0] ren_src_ready [iq_pkg::NUM_LANES];
    logic wb_valid [iq_pkg::NUM_WB];
    logic wb_uses_rd [iq_pkg::NUM_WB];
    iq_pkg::pr_tag_t wb_rd [iq_pkg::NUM_WB];
    logic recall;
    iq_pkg::al_tag_t new_front;
    iq_pkg::al_tag_t old_front;
    logic stall;
    logic iss_valid [iq_pkg::NUM_LANES];
    iq_pkg::iq_entry_t iss_entry [iq_pkg::NUM_LANES];

    // accepted ops in the order they must issue
    iq_pkg::iq_entry_t model [$];
    integer seed;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    mem_issue_queue dut (
        .clk             (clk),
        .reset           (reset),
        .i_ren_valid     (ren_valid),
        .i_ren_entry     (ren_entry),
        .i_ren_src_ready (ren_src_ready),
        .i_wb_valid      (wb_valid),
        .i_wb_uses_rd    (wb_uses_rd),
        .i_wb_rd         (wb_rd),
        .i_recall        (recall),
        .i_new_front     (new_front),
        .i_old_front     (old_front),
        .o_stall         (stall),
        .o_iss_valid     (iss_valid),
        .o_iss_entry     (iss_entry)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic entry_check(input string name, input iq_pkg::iq_entry_t got,
                               input iq_pkg::iq_entry_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // every issued op must be the oldest op still expected
    always @(negedge clk) begin
        if (!reset) begin
            if (iss_valid[1] === 1'b1 && iss_valid[0] !== 1'b1) begin
                $display("ERROR t=%0t issue lane 1 is valid without lane 0", $time);
                errors++;
            end
            for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
                if (iss_valid[l] === 1'b1) begin
                    if (model.size() == 0) begin
                        $display("ERROR t=%0t lane %0d issued an op that was never accepted",
                                 $time, l);
                        errors++;
                    end else begin
                        entry_check($sformatf("o_iss_entry[%0d]", l), iss_entry[l],
                                    model.pop_front());
                    end
                end
            end
        end
    end

    function automatic iq_pkg::iq_entry_t make_entry(input logic mem, input logic csr,
            input logic [1:0] uses_src, input iq_pkg::pr_tag_t rs1,
            input iq_pkg::pr_tag_t rs2, input iq_pkg::al_tag_t al);
        iq_pkg::iq_entry_t e;
        logic [31:0] rnd;
        rnd = $random(seed);
        e.pc = rnd;
        rnd = $random(seed);
        e.imm = rnd;
        rnd = $random(seed);
        e.rd = rnd[5:0];
        e.uses_rd = rnd[6];
        e.uses_imm = rnd[7];
        e.mem_op = rnd[8] ? iq_pkg::MEM_WRITE : iq_pkg::MEM_READ;
        case (rnd[11:9])
            3'd0: e.width = iq_pkg::W_BYTE;
            3'd1: e.width = iq_pkg::W_HALF;
            3'd2: e.width = iq_pkg::W_WORD;
            3'd3: e.width = iq_pkg::W_UBYTE;
            default: e.width = iq_pkg::W_UHALF;
        endcase
        e.rs1 = rs1;
        e.rs2 = rs2;
        e.uses_rs1 = uses_src[0];
        e.uses_rs2 = uses_src[1];
        e.is_mem_access = mem;
        e.accesses_csr = csr;
        e.al_addr = al;
        return e;
    endfunction

    task automatic drive_lane(input int l, input iq_pkg::iq_entry_t e, input logic [1:0] rdy);
        ren_valid[l] = 1'b1;
        ren_entry[l] = e;
        ren_src_ready[l] = rdy;
    endtask

    task automatic drive_wb(input int port, input iq_pkg::pr_tag_t tag);
        wb_valid[port] = 1'b1;
        wb_uses_rd[port] = 1'b1;
        wb_rd[port] = tag;
    endtask

    // one cycle of whatever is driven; counting lanes enter the model when accepted
    task automatic step(input logic exp_stall);
        @(negedge clk);
        flag_check("o_stall", stall, exp_stall);
        @(posedge clk);
        if (!exp_stall && !recall) begin
            for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
                if (ren_valid[l] && (ren_entry[l].is_mem_access || ren_entry[l].accesses_csr)) begin
                    model.push_back(ren_entry[l]);
                end
            end
        end
        #1;
        for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
            ren_valid[l] = 1'b0;
        end
        for (int p = 0; p < iq_pkg::NUM_WB; p++) begin
            wb_valid[p] = 1'b0;
        end
        recall = 1'b0;
    endtask

    task automatic expect_issue(input logic v0, input logic v1);
        @(negedge clk);
        flag_check("o_iss_valid[0]", iss_valid[0], v0);
        flag_check("o_iss_valid[1]", iss_valid[1], v1);
        @(posedge clk);
        #1;
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        while (model.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (model.size() != 0) begin
            $display("ERROR t=%0t queue did not drain, %0d ops never issued", $time,
                     model.size());
            errors++;
        end
        // quiet window so a stray issue is still seen
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic reset_state();
        step(1'b0);
        expect_issue(1'b0, 1'b0);
    endtask

    task automatic single_issue();
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd0), 2'b11);
        // neither memory nor csr, so it must be dropped
        drive_lane(1, make_entry(1'b0, 1'b0, 2'b11, 6'd1, 6'd2, 6'd1), 2'b11);
        step(1'b0);
        expect_issue(1'b0, 1'b0);
        expect_issue(1'b1, 1'b0);
        drain_queue();
    endtask

    task automatic dual_issue_in_order();
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd2), 2'b11);
        drive_lane(1, make_entry(1'b0, 1'b1, 2'b01, 6'd3, 6'd0, 6'd3), 2'b11);
        step(1'b0);
        expect_issue(1'b0, 1'b0);
        expect_issue(1'b1, 1'b1);
        drain_queue();
        // back entry waits on rs1, the younger one is ready
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b01, 6'd40, 6'd0, 6'd4), 2'b10);
        drive_lane(1, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd5), 2'b11);
        step(1'b0);
        repeat (3) expect_issue(1'b0, 1'b0);
        drive_wb(0, 6'd40);
        step(1'b0);
        expect_issue(1'b0, 1'b0);
        expect_issue(1'b1, 1'b1);
        drain_queue();
    endtask

    task automatic same_cycle_wakeup();
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd41, 6'd6), 2'b01);
        drive_wb(1, 6'd41);
        step(1'b0);
        expect_issue(1'b0, 1'b0);
        expect_issue(1'b1, 1'b0);
        drain_queue();
    endtask

    task automatic stall_when_full();
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b01, 6'd42, 6'd0, 6'd7), 2'b00);
        step(1'b0);
        // seven pairs bring the occupancy to 15
        for (int k = 0; k < 7; k++) begin
            drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2,
                                     iq_pkg::al_tag_t'(8 + 2 * k)), 2'b11);
            drive_lane(1, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2,
                                     iq_pkg::al_tag_t'(9 + 2 * k)), 2'b11);
            step(1'b0);
        end
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd30), 2'b11);
        drive_lane(1, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd31), 2'b11);
        step(1'b1);
        drive_lane(0, make_entry(1'b0, 1'b1, 2'b11, 6'd1, 6'd2, 6'd32), 2'b11);
        step(1'b1);
        step(1'b0);
        expect_issue(1'b0, 1'b0);
        drive_wb(2, 6'd42);
        step(1'b0);
        drain_queue();
    endtask

    task automatic recall_flush();
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b01, 6'd43, 6'd0, 6'd61), 2'b00);
        drive_lane(1, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd62), 2'b11);
        step(1'b0);
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd63), 2'b11);
        drive_lane(1, make_entry(1'b0, 1'b1, 2'b11, 6'd1, 6'd2, 6'd0), 2'b11);
        step(1'b0);
        expect_issue(1'b0, 1'b0);
        // wrapping range [63, 1) takes the two youngest
        recall = 1'b1;
        new_front = 6'd63;
        old_front = 6'd1;
        step(1'b0);
        void'(model.pop_back());
        void'(model.pop_back());
        drive_lane(0, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd63), 2'b11);
        drive_lane(1, make_entry(1'b1, 1'b0, 2'b11, 6'd1, 6'd2, 6'd0), 2'b11);
        step(1'b0);
        drive_wb(3, 6'd43);
        step(1'b0);
        drain_queue();
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int e0;
        seed = 32'h750d2f8e;
        clk = 1'b0;
        reset = 1'b1;
        recall = 1'b0;
        new_front = '0;
        old_front = '0;
        for (int l = 0; l < iq_pkg::NUM_LANES; l++) begin
            ren_valid[l] = 1'b0;
            ren_entry[l] = '0;
            ren_src_ready[l] = 2'b00;
        end
        for (int p = 0; p < iq_pkg::NUM_WB; p++) begin
            wb_valid[p] = 1'b0;
            wb_uses_rd[p] = 1'b0;
            wb_rd[p] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        e0 = errors;
        reset_state();
        report_test("reset", e0);
        e0 = errors;
        single_issue();
        report_test("single issue", e0);
        e0 = errors;
        dual_issue_in_order();
        report_test("dual issue and in-order blocking", e0);
        e0 = errors;
        same_cycle_wakeup();
        report_test("same-cycle wakeup", e0);
        e0 = errors;
        stall_when_full();
        report_test("stall", e0);
        e0 = errors;
        recall_flush();
        report_test("recall", e0);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
iq_pkg.sv
iq_alloc_if.sv
iq_alloc.sv
iq_flush.sv
iq_wakeup.sv
iq_entries.sv
mem_issue_queue.sv
tb_mem_issue_queue.sv

// ==== Makefile ====
TOP = tb_mem_issue_queue

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
